//--- logic/muldiv_macros.svh
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// width of operands and results
`define MULDIV_XLEN 64

// width of the transaction tag that travels with each operation
`define MULDIV_TAG_BITS 3

// width of a shift count
// must hold every value from 0 up to MULDIV_XLEN inclusive
`define MULDIV_SHIFT_BITS 7

// the tag width is sized for a small reorder window
// widen it if the issue logic keeps more operations in flight

`endif

//--- logic/muldiv_op_pkg.sv
package muldiv_op_pkg;

    // --------------------
    // operator encoding
    // --------------------
    // multiplies sit in the lower half of the encoding, divides in the upper half
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHU  = 3'd2,
        MULHSU = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_e;

    // true for operators that go to the serial divider
    function automatic logic op_is_div(muldiv_op_e op);
        return op inside {DIV, DIVU, REM, REMU};
    endfunction

endpackage

//--- logic/muldiv_data_pkg.sv
package muldiv_data_pkg;

    `include "muldiv_macros.svh"

    // operand and result word
    typedef logic [`MULDIV_XLEN-1:0] word_t;

    // transaction tag
    typedef logic [`MULDIV_TAG_BITS-1:0] tag_t;

    // divisor normalization count
    // also the iteration counter of the divider
    typedef logic [`MULDIV_SHIFT_BITS-1:0] shift_t;

endpackage

//--- logic/lead_zero_count.sv
`timescale 1ns/1ps

`include "muldiv_macros.svh"

module lead_zero_count
    import muldiv_data_pkg::*;
(
    input  word_t  word_i,
    output shift_t count_o,
    output logic   empty_o
);

    localparam int unsigned num_levels = $clog2(`MULDIV_XLEN);

    // per tree level: any bit set in a node, and index of its lowest set bit
    logic [`MULDIV_XLEN-1:0] hit [num_levels+1];
    logic [num_levels-1:0]   idx [num_levels+1][`MULDIV_XLEN];

    // pairwise reduction, one mux level per tree level
    always_comb begin
        for (int l = 0; l <= num_levels; l++) begin
            hit[l] = '0;
            for (int n = 0; n < `MULDIV_XLEN; n++) begin
                idx[l][n] = '0;
            end
        end
        hit[0] = word_i;
        for (int l = 1; l <= num_levels; l++) begin
            for (int n = 0; n < (`MULDIV_XLEN >> l); n++) begin
                hit[l][n] = hit[l-1][2*n] | hit[l-1][2*n+1];
                // lower child wins, upper child adds half the node width
                if (hit[l-1][2*n]) begin
                    idx[l][n] = idx[l-1][2*n];
                end else begin
                    idx[l][n]      = idx[l-1][2*n+1];
                    idx[l][n][l-1] = 1'b1;
                end
            end
        end
    end

    assign count_o = shift_t'(idx[num_levels][0]);
    assign empty_o = ~hit[num_levels][0];

endmodule

//--- logic/div_operand_prep.sv
`timescale 1ns/1ps

`include "muldiv_macros.svh"

module div_operand_prep
    import muldiv_op_pkg::*;
    import muldiv_data_pkg::*;
(
    input  muldiv_op_e op_i,
    input  word_t      divisor_i,
    output logic       signed_o,
    output logic       rem_o,
    output logic       divisor_neg_o,
    output word_t      divisor_shifted_o,
    output shift_t     shift_o
);

    // bit-reversed divisor, so a trailing count gives the leading count
    word_t  divisor_rev;
    word_t  lzc_in;
    shift_t lzc_count;
    logic   lzc_empty;

    // --------------------
    // operator decode
    // --------------------
    // signed flavours of divide and remainder
    assign signed_o = op_i inside {DIV, REM};

    // remainder selects the partial remainder at the end instead of the quotient
    assign rem_o = op_i inside {REM, REMU};

    // only a signed operation looks at the sign bit
    assign divisor_neg_o = signed_o & divisor_i[`MULDIV_XLEN-1];

    // --------------------
    // normalization
    // --------------------
    assign divisor_rev = {<<{divisor_i}};

    // positive divisor counts leading zeros
    // negative divisor counts leading ones
    assign lzc_in = divisor_neg_o ? ~divisor_rev : divisor_rev;

    lead_zero_count u_lzc (
        .word_i  (lzc_in),
        .count_o (lzc_count),
        .empty_o (lzc_empty)
    );

    // no significant bit at all means zero or minus one
    // in that case run the full width
    assign shift_o = lzc_empty ? shift_t'(`MULDIV_XLEN) : lzc_count;

    // a negative divisor may lose its sign bit here
    // the divider puts it back through its sign flag while shifting right
    assign divisor_shifted_o = divisor_i << shift_o;

endmodule

//--- logic/pipe_multiplier.sv
`timescale 1ns/1ps

`include "muldiv_macros.svh"

module pipe_multiplier
    import muldiv_op_pkg::*;
    import muldiv_data_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       valid_i,
    input  muldiv_op_e op_i,
    input  word_t      operand_a_i,
    input  word_t      operand_b_i,
    input  tag_t       tag_i,
    output logic       valid_o,
    output word_t      result_o,
    output tag_t       tag_o
);

    logic sign_a;
    logic sign_b;

    // operands widened by one bit so one signed multiply covers all three flavours
    logic signed [`MULDIV_XLEN:0]     op_a_ext;
    logic signed [`MULDIV_XLEN:0]     op_b_ext;
    logic signed [2*`MULDIV_XLEN+1:0] product;

    logic  valid_q;
    word_t result_q;
    tag_t  tag_q;

    // sign select
    // MUL takes the low half, which is the same for any sign choice
    assign sign_a = op_i inside {MULH, MULHSU};
    assign sign_b = (op_i == MULH);

    assign op_a_ext = $signed({operand_a_i[`MULDIV_XLEN-1] & sign_a, operand_a_i});
    assign op_b_ext = $signed({operand_b_i[`MULDIV_XLEN-1] & sign_b, operand_b_i});
    assign product  = op_a_ext * op_b_ext;

    // --------------------
    // output stage
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // result and tag only load on an accepted multiply
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            tag_q <= tag_i;
            if (op_i == MUL) begin
                result_q <= product[`MULDIV_XLEN-1:0];
            end else begin
                result_q <= product[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
            end
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;
    assign tag_o    = tag_q;

endmodule

//--- logic/serial_divider.sv
`timescale 1ns/1ps

`include "muldiv_macros.svh"

module serial_divider
    import muldiv_data_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   in_valid_i,
    output logic   in_ready_o,
    input  tag_t   tag_i,
    input  word_t  dividend_i,
    input  word_t  divisor_shifted_i,
    input  shift_t shift_i,
    input  logic   signed_i,
    input  logic   rem_i,
    input  logic   divisor_neg_i,
    input  logic   out_ready_i,
    output logic   out_valid_o,
    output tag_t   tag_o,
    output word_t  result_o
);

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        FINISH
    } div_state_e;

    div_state_e state_q;
    div_state_e state_d;

    // fsm strobes
    logic load;
    logic step;

    // issue-time decode
    logic b_zero;
    logic negate;

    // datapath
    logic  comp;
    logic  cnt_zero;
    word_t diff;
    word_t out_sel;

    // partial remainder, shifted divisor, quotient bits
    word_t  a_q;
    word_t  b_q;
    word_t  quot_q;
    tag_t   tag_q;
    shift_t cnt_q;

    // flags latched at load
    logic rem_sel_q;
    logic comp_inv_q;
    logic res_inv_q;
    logic b_zero_q;

    // negative divisors never shift down to all zero, so exclude them
    assign b_zero = ~(|divisor_shifted_i) & ~divisor_neg_i;

    // signs differ, so work in the domain of the divisor and flip at the end
    assign negate = signed_i & (dividend_i[`MULDIV_XLEN-1] ^ divisor_neg_i);

    // --------------------
    // compare and subtract
    // --------------------
    // |a| >= |b| in whichever sign domain the divisor sits
    // a zero remainder never subtracts, except when dividing by zero
    assign comp = ((a_q == b_q) | ((a_q > b_q) ^ comp_inv_q)) & ((|a_q) | b_zero_q);
    assign diff = a_q - b_q;

    assign cnt_zero = (cnt_q == '0);

    // --------------------
    // fsm
    // --------------------
    always_comb begin
        state_d     = state_q;
        in_ready_o  = 1'b0;
        out_valid_o = 1'b0;
        load        = 1'b0;
        step        = 1'b0;
        case (state_q)
            IDLE: begin
                in_ready_o = 1'b1;
                if (in_valid_i) begin
                    load    = 1'b1;
                    state_d = DIVIDE;
                end
            end
            // shift_i + 1 steps, last one taken with the counter at zero
            DIVIDE: begin
                step = 1'b1;
                if (cnt_zero) begin
                    state_d = FINISH;
                end
            end
            // hold the result until the output port is ours
            FINISH: begin
                out_valid_o = 1'b1;
                if (out_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            cnt_q      <= '0;
            rem_sel_q  <= 1'b0;
            comp_inv_q <= 1'b0;
            res_inv_q  <= 1'b0;
            b_zero_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (load) begin
                cnt_q      <= shift_i;
                rem_sel_q  <= rem_i;
                comp_inv_q <= divisor_neg_i;
                b_zero_q   <= b_zero;
                // quotient of a division by zero stays all ones
                res_inv_q  <= (~b_zero | rem_i) & negate;
            end else if (step && !cnt_zero) begin
                cnt_q <= cnt_q - shift_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            a_q    <= negate ? -dividend_i : dividend_i;
            b_q    <= divisor_shifted_i;
            quot_q <= '0;
            tag_q  <= tag_i;
        end else if (step) begin
            if (comp) begin
                a_q <= diff;
            end
            // sign flag refills the top, acting as bit 64 of the divisor
            b_q    <= {comp_inv_q, b_q[`MULDIV_XLEN-1:1]};
            quot_q <= {quot_q[`MULDIV_XLEN-2:0], comp};
        end
    end

    // --------------------
    // result correction
    // --------------------
    assign out_sel  = rem_sel_q ? a_q : quot_q;
    assign result_o = res_inv_q ? -out_sel : out_sel;
    assign tag_o    = tag_q;

endmodule

//--- logic/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit
    import muldiv_op_pkg::*;
    import muldiv_data_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       valid_i,
    input  muldiv_op_e op_i,
    input  word_t      operand_a_i,
    input  word_t      operand_b_i,
    input  tag_t       tag_i,
    output logic       ready_o,
    output logic       valid_o,
    output word_t      result_o,
    output tag_t       tag_o
);

    // --------------------
    // input steering
    // --------------------
    logic mul_valid_in;
    logic div_valid_in;

    // multiplier is always ready, so ready_o only reflects the divider
    assign mul_valid_in = valid_i & ~op_is_div(op_i);
    assign div_valid_in = valid_i & op_is_div(op_i);

    // --------------------
    // multiplier
    // --------------------
    logic  mul_valid;
    word_t mul_result;
    tag_t  mul_tag;

    pipe_multiplier u_mul (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (mul_valid_in),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .tag_i       (tag_i),
        .valid_o     (mul_valid),
        .result_o    (mul_result),
        .tag_o       (mul_tag)
    );

    // --------------------
    // divider
    // --------------------
    logic   div_signed;
    logic   div_rem;
    logic   div_neg;
    word_t  div_b_shifted;
    shift_t div_shift;
    logic   div_out_ready;
    logic   div_valid;
    word_t  div_result;
    tag_t   div_tag;

    // operator decode and divisor normalization, same cycle as issue
    div_operand_prep u_prep (
        .op_i              (op_i),
        .divisor_i         (operand_b_i),
        .signed_o          (div_signed),
        .rem_o             (div_rem),
        .divisor_neg_o     (div_neg),
        .divisor_shifted_o (div_b_shifted),
        .shift_o           (div_shift)
    );

    serial_divider u_div (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .in_valid_i        (div_valid_in),
        .in_ready_o        (ready_o),
        .tag_i             (tag_i),
        .dividend_i        (operand_a_i),
        .divisor_shifted_i (div_b_shifted),
        .shift_i           (div_shift),
        .signed_i          (div_signed),
        .rem_i             (div_rem),
        .divisor_neg_i     (div_neg),
        .out_ready_i       (div_out_ready),
        .out_valid_o       (div_valid),
        .tag_o             (div_tag),
        .result_o          (div_result)
    );

    // --------------------
    // output arbitration
    // --------------------
    // multiplier cannot stall, so it wins the port
    // divider parks in its finish state until the port is free
    assign div_out_ready = ~mul_valid;
    assign valid_o       = mul_valid | div_valid;
    assign result_o      = mul_valid ? mul_result : div_result;
    assign tag_o         = mul_valid ? mul_tag : div_tag;

endmodule

//--- verif/muldiv_tb_clkgen.sv
`timescale 1ns/1ps

module muldiv_tb_clkgen (
    output logic clk_o,
    output logic rst_no
);

    localparam time half_period = 20ns;
    localparam int unsigned reset_cycles = 16;

    // free running clock, 40 ns period
    initial begin
        clk_o = 1'b0;
        forever #(half_period) clk_o = ~clk_o;
    end

    // reset held low for reset_cycles edges, released away from the rising edge
    initial begin
        rst_no = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- verif/muldiv_tb.sv
`timescale 1ns/1ps

`include "muldiv_macros.svh"

module muldiv_tb
    import muldiv_op_pkg::*;
    import muldiv_data_pkg::*;
;

    localparam int max_entries = 64;
    localparam int num_random = 16;
    localparam word_t ones = '1;
    localparam word_t min_neg = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};

    logic       clk_i;
    logic       rst_ni;
    logic       valid_i;
    logic       ready_o;
    logic       valid_o;
    muldiv_op_e op_i;
    word_t      operand_a_i;
    word_t      operand_b_i;
    word_t      result_o;
    tag_t       tag_i;
    tag_t       tag_o;

    // stimulus table with one row per operation
    string      tbl_name [max_entries];
    muldiv_op_e tbl_op   [max_entries];
    word_t      tbl_a    [max_entries];
    word_t      tbl_b    [max_entries];
    word_t      tbl_exp  [max_entries];
    tag_t       tbl_tag  [max_entries];
    int         num_entries = 0;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit = 0;
    integer seed = 32'ha497_9a48;

    muldiv_tb_clkgen u_clkgen (.clk_o(clk_i), .rst_no(rst_ni));

    muldiv_unit u_dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .tag_i       (tag_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .tag_o       (tag_o)
    );

    // --------------------
    // helpers
    // --------------------
    // reference product built from operand magnitudes and the sign of the result
    function automatic word_t mul_ref(muldiv_op_e op, word_t a, word_t b);
        logic [2*`MULDIV_XLEN-1:0] prod;
        word_t mag_a;
        word_t mag_b;
        logic  neg;
        mag_a = a;
        mag_b = b;
        neg = 1'b0;
        if ((op == MULH || op == MULHSU) && a[`MULDIV_XLEN-1]) begin
            mag_a = -a;
            neg = ~neg;
        end
        if (op == MULH && b[`MULDIV_XLEN-1]) begin
            mag_b = -b;
            neg = ~neg;
        end
        prod = {{`MULDIV_XLEN{1'b0}}, mag_a} * {{`MULDIV_XLEN{1'b0}}, mag_b};
        if (neg) begin
            prod = -prod;
        end
        return (op == MUL) ? prod[`MULDIV_XLEN-1:0] : prod[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
    endfunction

    // row tag is the low bits of its index
    task automatic add_entry(string name, muldiv_op_e op, word_t a, word_t b, word_t exp);
        tbl_name[num_entries] = name;
        tbl_op[num_entries]   = op;
        tbl_a[num_entries]    = a;
        tbl_b[num_entries]    = b;
        tbl_exp[num_entries]  = exp;
        tbl_tag[num_entries]  = tag_t'(num_entries);
        num_entries++;
    endtask

    task automatic drive(muldiv_op_e op, word_t a, word_t b, tag_t tag);
        valid_i     = 1'b1;
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
        tag_i       = tag;
    endtask

    task automatic check_output(int idx);
        checks++;
        if (!valid_o) begin
            errors++;
            $display("test %s produced no valid output when expected", tbl_name[idx]);
        end else begin
            if (result_o !== tbl_exp[idx]) begin
                errors++;
                $display("[FAIL] %s result: expected %h, actual %h",
                         tbl_name[idx], tbl_exp[idx], result_o);
            end
            if (tag_o !== tbl_tag[idx]) begin
                errors++;
                $display("[FAIL] %s tag: expected %0d, actual %0d",
                         tbl_name[idx], tbl_tag[idx], tag_o);
            end
        end
    endtask

    // division held in finish while a stream of multiplies owns the output port
    task automatic run_collision();
        word_t exp_res[$];
        tag_t  exp_tag[$];
        int    issued;
        int    seen;
        issued = 0;
        seen   = 0;
        // six multiplies in issue order, then the held remainder
        for (int k = 0; k < 6; k++) begin
            exp_res.push_back(word_t'((k + 2) * (k + 3)));
            exp_tag.push_back(tag_t'(k));
        end
        exp_res.push_back(64'h1000_0000_0000_0000);
        exp_tag.push_back(3'd7);
        @(negedge clk_i);
        while (!ready_o) @(negedge clk_i);
        // divisor already normalized, so the division needs a single step
        drive(REMU, 64'h9000_0000_0000_0000, min_neg, 3'd7);
        while (seen < 7) begin
            @(negedge clk_i);
            if (valid_o) begin
                checks++;
                if (result_o !== exp_res[seen] || tag_o !== exp_tag[seen]) begin
                    errors++;
                    $display("[FAIL] collision_%0d: expected tag %0d %h, actual tag %0d %h",
                             seen, exp_tag[seen], exp_res[seen], tag_o, result_o);
                end
                seen++;
            end
            if (issued < 6) begin
                drive(MUL, word_t'(issued + 2), word_t'(issued + 3), tag_t'(issued));
                issued++;
            end else begin
                valid_i = 1'b0;
            end
        end
        valid_i = 1'b0;
    endtask

    // --------------------
    // watchdog
    // --------------------
    always @(posedge clk_i) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        logic [31:0] rnd;
        word_t       ra;
        word_t       rb;
        muldiv_op_e  rop;
        int          pending;
        valid_i     = 1'b0;
        op_i        = MUL;
        operand_a_i = '0;
        operand_b_i = '0;
        tag_i       = '0;

        add_entry("mul_small", MUL, 3, 5, 15);
        add_entry("mul_neg_pos", MUL, -64'sd3, 7, -64'sd21);
        add_entry("mulh_neg_neg", MULH, -64'sd3, -64'sd7, 0);
        add_entry("mulh_min_min", MULH, min_neg, min_neg, 64'h4000_0000_0000_0000);
        add_entry("mulh_pos_neg", MULH, 64'h4000_0000_0000_0000, ones, ones);
        add_entry("mulhu_ones", MULHU, ones, ones, 64'hFFFF_FFFF_FFFF_FFFE);
        add_entry("mulhsu_neg_ones", MULHSU, ones, ones, ones);
        add_entry("mulhsu_pos_ones", MULHSU, 64'h4000_0000_0000_0000, ones,
                  64'h3FFF_FFFF_FFFF_FFFF);
        add_entry("mul_ones", MUL, ones, ones, 1);
        add_entry("div_pos_pos", DIV, 20, 6, 3);
        add_entry("rem_pos_pos", REM, 20, 6, 2);
        add_entry("div_neg_pos", DIV, -64'sd20, 6, -64'sd3);
        add_entry("rem_neg_pos", REM, -64'sd20, 6, -64'sd2);
        add_entry("div_pos_neg", DIV, 20, -64'sd6, -64'sd3);
        add_entry("rem_pos_neg", REM, 20, -64'sd6, 2);
        add_entry("div_neg_neg", DIV, -64'sd20, -64'sd6, 3);
        add_entry("rem_neg_neg", REM, -64'sd20, -64'sd6, -64'sd2);
        add_entry("divu_small", DIVU, 100, 7, 14);
        add_entry("remu_small", REMU, 100, 7, 2);
        add_entry("divu_ones_by_3", DIVU, ones, 3, 64'h5555_5555_5555_5555);
        add_entry("remu_ones_by_3", REMU, ones, 3, 0);
        add_entry("divu_large", DIVU, 64'hF000_0000_0000_0000, 64'h8000_0000_0000_0001, 1);
        add_entry("remu_large", REMU, 64'hF000_0000_0000_0000, 64'h8000_0000_0000_0001,
                  64'h6FFF_FFFF_FFFF_FFFF);
        add_entry("div_by_one", DIV, 64'h7FFF_FFFF_FFFF_FFFF, 1, 64'h7FFF_FFFF_FFFF_FFFF);
        add_entry("rem_by_one", REM, 12345, 1, 0);
        add_entry("div_neg_by_m1", DIV, -64'sd9, -64'sd1, 9);
        add_entry("divu_by_ones", DIVU, 5, ones, 0);
        add_entry("remu_by_ones", REMU, 5, ones, 5);
        // division by zero
        add_entry("div_by_zero", DIV, 42, 0, ones);
        add_entry("div_neg_by_zero", DIV, -64'sd5, 0, ones);
        add_entry("divu_by_zero", DIVU, 42, 0, ones);
        add_entry("rem_by_zero", REM, -64'sd42, 0, -64'sd42);
        add_entry("remu_by_zero", REMU, 42, 0, 42);
        // signed overflow
        add_entry("div_overflow", DIV, min_neg, -64'sd1, min_neg);
        add_entry("rem_overflow", REM, min_neg, -64'sd1, 0);

        // random multiplies issued back to back
        for (int k = 0; k < num_random; k++) begin
            rnd = $random(seed);
            rop = muldiv_op_e'({1'b0, rnd[1:0]});
            ra  = {$random(seed), $random(seed)};
            rb  = {$random(seed), $random(seed)};
            add_entry($sformatf("rand_mul_%0d", k), rop, ra, rb, mul_ref(rop, ra, rb));
        end
        // collision sequence counts as eight more entries
        cycle_limit = 16 + 80 * (num_entries + 8);

        @(posedge rst_ni);
        @(negedge clk_i);
        checks++;
        if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
            errors++;
            $display("after reset valid_o is %b and ready_o is %b, expected 0 and 1",
                     valid_o, ready_o);
        end

        // a multiply is checked on the edge after issue while the next one is driven
        pending = -1;
        for (int i = 0; i < num_entries; i++) begin
            @(negedge clk_i);
            if (pending >= 0) begin
                check_output(pending);
                pending = -1;
            end
            if (op_is_div(tbl_op[i])) begin
                valid_i = 1'b0;
                while (!ready_o) @(negedge clk_i);
                drive(tbl_op[i], tbl_a[i], tbl_b[i], tbl_tag[i]);
                @(negedge clk_i);
                valid_i = 1'b0;
                while (!valid_o) @(negedge clk_i);
                check_output(i);
            end else begin
                drive(tbl_op[i], tbl_a[i], tbl_b[i], tbl_tag[i]);
                pending = i;
            end
        end
        @(negedge clk_i);
        valid_i = 1'b0;
        if (pending >= 0) begin
            check_output(pending);
        end

        run_collision();

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+logic
logic/muldiv_op_pkg.sv
logic/muldiv_data_pkg.sv
logic/lead_zero_count.sv
logic/div_operand_prep.sv
logic/pipe_multiplier.sv
logic/serial_divider.sv
logic/muldiv_unit.sv
verif/muldiv_tb_clkgen.sv
verif/muldiv_tb.sv
